// ==== dma_sched.f ====
+incdir+hdl
hdl/dma_sched_pkg.sv
hdl/seq_queue.sv
hdl/dma_rr_arbiter.sv
hdl/beat_demux.sv
hdl/dma_sched_top.sv
tests/dma_sched_props.sv
tests/dma_sched_checker.sv
tests/dma_sched_tb.sv

// ==== tests/dma_sched_tb.sv ====
/*
 * Testbench for the DMA request scheduler.
 * Drives region requests, models the DMA engine and runs five tests;
 * the checker instance does the comparing.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module dma_sched_tb;

  import dma_sched_pkg::*;

  localparam integer LIMIT = 2000;

  logic                             aclk;
  logic                             aresetn;
  logic [`N_REGIONS-1:0]            s_valid;
  logic [`N_REGIONS-1:0]            s_ready;
  dma_req_t [`N_REGIONS-1:0]        s_req;
  dma_rsp_t [`N_REGIONS-1:0]        s_rsp;
  logic                             m_valid;
  logic                             m_ready;
  dma_req_t                         m_req;
  logic                             done_in;
  logic                             rd_valid;
  logic                             rd_ready;
  logic [`DATA_BITS-1:0]            rd_data;
  logic [`N_REGIONS-1:0]            u_valid;
  logic [`N_REGIONS-1:0]            u_ready;
  logic [`DATA_BITS-1:0]            u_data;
  logic                             u_last;

  // Engine model state
  dma_req_t eng_q [$];
  logic     eng_busy = 1'b0;
  logic     eng_hold = 1'b0;
  logic     m_rand   = 1'b0;
  logic     u_rand   = 1'b0;
  integer   tb_err   = 0;
  integer   n_pass   = 0;
  integer   n_fail   = 0;
  integer   err_mark = 0;

  dma_sched_top dut0 (.*);

  dma_sched_checker chk0 (.*);

  bind dma_sched_top dma_sched_props props0 (
    .aclk(aclk), .aresetn(aresetn), .m_valid(m_valid), .m_ready(m_ready),
    .m_req(m_req), .s_rsp(s_rsp), .u_valid(u_valid), .rd_valid(rd_valid)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Scoreboard, testbench and assertion errors together
  function automatic integer total_errors();
    total_errors = chk0.err_cnt + tb_err + dut0.props0.fail_cnt;
  endfunction

  // --------------------------------------------------------------------------
  // Engine model
  // --------------------------------------------------------------------------

  // Random ready towards the arbiter and from the regions
  initial forever begin
    @(posedge aclk);
    #1;
    m_ready = m_rand ? 1'($urandom) : 1'b1;
    u_ready = u_rand ? `N_REGIONS'($urandom) : '1;
  end

  initial forever begin
    @(posedge aclk);
    if (aresetn && m_valid && m_ready) eng_q.push_back(m_req);
  end

  // Beats in request order, then the done strobe
  initial forever begin
    dma_req_t req;
    integer   n;
    integer   t;
    @(posedge aclk);
    if (eng_q.size() > 0 && !eng_hold) begin
      eng_busy = 1'b1;
      req = eng_q.pop_front();
      n = (int'(req.len) + `DATA_BITS / 8 - 1) / (`DATA_BITS / 8);
      for (int k = 0; k < n; k++) begin
        #1;
        rd_valid = 1'b1;
        rd_data  = chk0.expect_beat(req.vaddr, k);
        t = 0;
        @(posedge aclk);
        while (!rd_ready) begin
          t = t + 1;
          if (t > LIMIT) abort_run("rd_ready");
          @(posedge aclk);
        end
      end
      #1;
      rd_valid = 1'b0;
      if (req.ctl) begin
        done_in = 1'b1;
        @(posedge aclk);
        #1;
        done_in = 1'b0;
      end
      eng_busy = 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Region stimulus
  // --------------------------------------------------------------------------

  // ctl_mode 0 none, 1 all, 2 every other request
  task automatic send_reqs(input integer r, input integer count, input integer ctl_mode);
    integer t;
    @(posedge aclk);
    #1;
    for (int k = 0; k < count; k++) begin
      s_req[r].vaddr  = {r[7:0], k[7:0], 16'($urandom)};
      s_req[r].len    = `LEN_BITS'(1 + $urandom % 64);
      s_req[r].ctl    = (ctl_mode == 1) || (ctl_mode == 2 && k % 2 == 0);
      s_req[r].stream = 1'($urandom);
      s_req[r].dest   = `DEST_BITS'($urandom);
      s_req[r].pid    = `PID_BITS'($urandom);
      s_valid[r]      = 1'b1;
      t = 0;
      @(posedge aclk);
      while (!s_ready[r]) begin
        t = t + 1;
        if (t > LIMIT) abort_run("s_ready");
        @(posedge aclk);
      end
      #1;
    end
    s_valid[r] = 1'b0;
  endtask

  task automatic run_all(input integer count, input integer ctl_mode);
    fork
      send_reqs(0, count, ctl_mode);
      send_reqs(1, count, ctl_mode);
      send_reqs(2, count, ctl_mode);
      send_reqs(3, count, ctl_mode);
    join
  endtask

  // Drain, then report the test
  task automatic finish_test(input string name);
    integer t;
    integer errs;
    t = 0;
    while (eng_q.size() > 0 || eng_busy || chk0.pending() > 0) begin
      t = t + 1;
      if (t > LIMIT) abort_run("the engine to drain");
      @(posedge aclk);
    end
    errs = total_errors() - err_mark;
    err_mark = total_errors();
    if (errs == 0) n_pass = n_pass + 1;
    else n_fail = n_fail + 1;
    $display("test %s done, %0d errors", name, errs);
  endtask

  initial begin
    integer t;
    void'($urandom(90));
    aresetn = 1'b0;
    s_valid = '0;
    s_req   = '0;
    m_ready = 1'b0;
    done_in = 1'b0;
    rd_valid = 1'b0;
    rd_data = '0;
    u_ready = '0;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    chk0.test_name = "single";
    send_reqs(1, 1, 0);
    finish_test("single");

    chk0.test_name = "round_robin";
    m_rand = 1'b1;
    run_all(4, 0);
    finish_test("round_robin");

    chk0.test_name = "completion";
    run_all(3, 2);
    finish_test("completion");

    chk0.test_name = "backpressure";
    u_rand = 1'b1;
    run_all(4, 1);
    finish_test("backpressure");

    // Engine holds data back until both queues are full
    chk0.test_name = "queue_full";
    m_rand = 1'b0;
    u_rand = 1'b0;
    eng_hold = 1'b1;
    send_reqs(0, `N_OUTSTANDING, 1);
    s_req[0].len = `LEN_BITS'(16);
    s_valid[0] = 1'b1;
    repeat (10) begin
      @(posedge aclk);
      if (s_ready[0]) begin
        $display("queue_full: s_ready high while both queues are full");
        tb_err = tb_err + 1;
      end
    end
    #1;
    eng_hold = 1'b0;
    t = 0;
    @(posedge aclk);
    while (!s_ready[0]) begin
      t = t + 1;
      if (t > LIMIT) abort_run("a grant after draining");
      @(posedge aclk);
    end
    #1;
    s_valid[0] = 1'b0;
    finish_test("queue_full");

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail,
             total_errors());
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/dma_sched_checker.sv ====
/*
 * Scoreboard for the scheduler testbench.
 * Models the round-robin pointer, expects beats and completions per region
 * from each granted request, and counts errors.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module dma_sched_checker (
  input wire logic                                     aclk,
  input wire logic                                     aresetn,
  input wire logic [`N_REGIONS-1:0]                    s_valid,
  input wire logic [`N_REGIONS-1:0]                    s_ready,
  input wire dma_sched_pkg::dma_req_t [`N_REGIONS-1:0] s_req,
  input wire dma_sched_pkg::dma_rsp_t [`N_REGIONS-1:0] s_rsp,
  input wire logic                                     m_valid,
  input wire logic                                     m_ready,
  input wire dma_sched_pkg::dma_req_t                  m_req,
  input wire logic [`N_REGIONS-1:0]                    u_valid,
  input wire logic [`N_REGIONS-1:0]                    u_ready,
  input wire logic [`DATA_BITS-1:0]                    u_data,
  input wire logic                                     u_last
);

  import dma_sched_pkg::*;

  localparam integer BPB = `DATA_BITS / 8;

  string  test_name = "none";
  integer err_cnt   = 0;
  integer ptr_model = 0;

  // Entry: region, last flag, data
  logic [`N_REGIONS_BITS+`DATA_BITS:0] beat_q [$];
  // Entry: region, pid, dest, stream
  logic [`N_REGIONS_BITS+`PID_BITS+`DEST_BITS:0] done_q [$];

  // Reference beat value for a request address and beat index
  function automatic logic [`DATA_BITS-1:0] expect_beat(input logic [`ADDR_BITS-1:0] vaddr,
                                                         input integer idx);
    expect_beat = {vaddr ^ 32'ha5c3_0f96, vaddr + 32'(idx * BPB)};
  endfunction

  function automatic integer pending();
    pending = beat_q.size() + done_q.size();
  endfunction

  // Beat count follows from the byte length, rounded up
  function automatic integer beats_of(input logic [`LEN_BITS-1:0] len);
    beats_of = (int'(len) + BPB - 1) / BPB;
  endfunction

  // --------------------------------------------------------------------------
  // Grants
  // --------------------------------------------------------------------------

  always @(posedge aclk) begin
    integer g;
    integer n;
    if (aresetn && m_valid && m_ready) begin
      g = -1;
      for (int i = 0; i < `N_REGIONS; i++) begin
        if (g < 0 && s_valid[(ptr_model + i) % `N_REGIONS]) begin
          g = (ptr_model + i) % `N_REGIONS;
        end
      end
      if (g < 0 || s_ready != (`N_REGIONS'(1) << g)) begin
        $display("mismatch %s grant expected %0d actual s_ready %b", test_name, g, s_ready);
        err_cnt = err_cnt + 1;
      end else if (m_req != s_req[g]) begin
        $display("mismatch %s m_req expected %h actual %h", test_name, s_req[g], m_req);
        err_cnt = err_cnt + 1;
      end
      if (g >= 0) begin
        n = beats_of(s_req[g].len);
        for (int k = 0; k < n; k++) begin
          beat_q.push_back({g[`N_REGIONS_BITS-1:0], k == n - 1,
                            expect_beat(s_req[g].vaddr, k)});
        end
        if (s_req[g].ctl) begin
          done_q.push_back({g[`N_REGIONS_BITS-1:0], s_req[g].pid, s_req[g].dest,
                            s_req[g].stream});
        end
      end
      ptr_model = (ptr_model + 1) % `N_REGIONS;
    end
  end

  // --------------------------------------------------------------------------
  // Beats and completions
  // --------------------------------------------------------------------------

  always @(posedge aclk) begin
    integer hit;
    logic [`DATA_BITS:0] got;
    logic [`PID_BITS+`DEST_BITS:0] rsp;
    if (aresetn) begin
      for (int r = 0; r < `N_REGIONS; r++) begin
        if (u_valid[r] && u_ready[r]) begin
          hit = -1;
          for (int i = 0; i < beat_q.size() && hit < 0; i++) begin
            if (beat_q[i][`N_REGIONS_BITS+`DATA_BITS:`DATA_BITS+1] == r) hit = i;
          end
          got = {u_last, u_data};
          if (hit < 0) begin
            $display("%s: region %0d got a beat it never asked for", test_name, r);
            err_cnt = err_cnt + 1;
          end else begin
            if (beat_q[hit][`DATA_BITS:0] != got) begin
              $display("mismatch %s beat region %0d expected %h actual %h", test_name, r,
                       beat_q[hit][`DATA_BITS:0], got);
              err_cnt = err_cnt + 1;
            end
            beat_q.delete(hit);
          end
        end
        if (s_rsp[r].done) begin
          hit = -1;
          for (int i = 0; i < done_q.size() && hit < 0; i++) begin
            if (done_q[i][`N_REGIONS_BITS+`PID_BITS+`DEST_BITS:`PID_BITS+`DEST_BITS+1] == r)
              hit = i;
          end
          rsp = {s_rsp[r].pid, s_rsp[r].dest, s_rsp[r].stream};
          if (hit < 0) begin
            $display("%s: region %0d got a done with no ctl request open", test_name, r);
            err_cnt = err_cnt + 1;
          end else begin
            if (done_q[hit][`PID_BITS+`DEST_BITS:0] != rsp) begin
              $display("mismatch %s done region %0d expected %h actual %h", test_name, r,
                       done_q[hit][`PID_BITS+`DEST_BITS:0], rsp);
              err_cnt = err_cnt + 1;
            end
            done_q.delete(hit);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/dma_sched_props.sv ====
/*
 * Concurrent assertions on the scheduler top level.
 * Attached to the DUT instance with bind from the testbench.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module dma_sched_props (
  input wire logic                                     aclk,
  input wire logic                                     aresetn,
  input wire logic                                     m_valid,
  input wire logic                                     m_ready,
  input wire dma_sched_pkg::dma_req_t                  m_req,
  input wire dma_sched_pkg::dma_rsp_t [`N_REGIONS-1:0] s_rsp,
  input wire logic [`N_REGIONS-1:0]                    u_valid,
  input wire logic                                     rd_valid
);

  logic [`N_REGIONS-1:0] done_bits;

  // Assertion failures so far
  integer fail_cnt = 0;

  always_comb begin
    for (int r = 0; r < `N_REGIONS; r++) begin
      done_bits[r] = s_rsp[r].done;
    end
  end

  // Stalled request holds its payload
  a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> $stable(m_req))
    else begin
      $error("m_req changed under stall");
      fail_cnt = fail_cnt + 1;
    end

  a_one_uvalid: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(u_valid))
    else begin
      $error("more than one u_valid high");
      fail_cnt = fail_cnt + 1;
    end

  a_one_done: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(done_bits))
    else begin
      $error("more than one done bit high");
      fail_cnt = fail_cnt + 1;
    end

  // No beat without engine data
  a_uvalid_rd: assert property (@(posedge aclk) disable iff (!aresetn)
    (u_valid != '0) |-> rd_valid)
    else begin
      $error("u_valid without rd_valid");
      fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

// ==== hdl/dma_sched_top.sv ====
/*
 * Top level of the DMA request scheduler.
 * Joins the round-robin arbiter to the read data demultiplexer
 * through the routing queue output.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module dma_sched_top (
  input  logic                                        aclk,
  input  logic                                        aresetn,

  // Region requests and completions
  input  logic [`N_REGIONS-1:0]                       s_valid,
  output logic [`N_REGIONS-1:0]                       s_ready,
  input  dma_sched_pkg::dma_req_t [`N_REGIONS-1:0]    s_req,
  output dma_sched_pkg::dma_rsp_t [`N_REGIONS-1:0]    s_rsp,

  // Engine request port and done strobe
  output logic                                        m_valid,
  input  logic                                        m_ready,
  output dma_sched_pkg::dma_req_t                     m_req,
  input  logic                                        done_in,

  // Engine read data
  input  logic                                        rd_valid,
  output logic                                        rd_ready,
  input  logic [`DATA_BITS-1:0]                       rd_data,

  // Region read data
  output logic [`N_REGIONS-1:0]                       u_valid,
  input  logic [`N_REGIONS-1:0]                       u_ready,
  output logic [`DATA_BITS-1:0]                       u_data,
  output logic                                        u_last
);

  import dma_sched_pkg::*;

  // Routing queue head
  logic       route_valid;
  logic       route_ready;
  route_rec_t route_rec;

  // Requests in, records out
  dma_rr_arbiter inst_arb (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .s_req       (s_req),
    .s_rsp       (s_rsp),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_req       (m_req),
    .done_in     (done_in),
    .route_valid (route_valid),
    .route_ready (route_ready),
    .route_rec   (route_rec)
  );

  // Beats back to regions
  beat_demux inst_demux (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .route_valid (route_valid),
    .route_ready (route_ready),
    .route_rec   (route_rec),
    .rd_valid    (rd_valid),
    .rd_ready    (rd_ready),
    .rd_data     (rd_data),
    .u_valid     (u_valid),
    .u_ready     (u_ready),
    .u_data      (u_data),
    .u_last      (u_last)
  );

endmodule

`default_nettype wire

// ==== hdl/beat_demux.sv ====
/*
 * Read data demultiplexer.
 * Sends engine read beats to the region named by the head routing record,
 * marks the last beat of each request and then pops that record.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module beat_demux (
  input  logic                             aclk,
  input  logic                             aresetn,

  // Head of the routing queue
  input  logic                             route_valid,
  output logic                             route_ready,
  input  dma_sched_pkg::route_rec_t        route_rec,

  // Engine read data
  input  logic                             rd_valid,
  output logic                             rd_ready,
  input  logic [`DATA_BITS-1:0]            rd_data,

  // Region read data
  output logic [`N_REGIONS-1:0]            u_valid,
  input  logic [`N_REGIONS-1:0]            u_ready,
  output logic [`DATA_BITS-1:0]            u_data,
  output logic                             u_last
);

  import dma_sched_pkg::*;

  // Beats already passed for the head request
  logic [BLEN_BITS-1:0] beat_cnt;
  logic                 is_last;
  logic                 beat;

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------

  // Data is shared, only valid is steered
  assign u_data = rd_data;

  // Addressed region only, and only with a record at the head
  always_comb begin
    u_valid                 = '0;
    u_valid[route_rec.vfid] = route_valid & rd_valid;
  end

  // Stall the engine on the addressed region
  assign rd_ready = route_valid & u_ready[route_rec.vfid];

  // One beat moves through
  assign beat = rd_valid & rd_ready;

  // --------------------------------------------------------------------------
  // Beat counting
  // --------------------------------------------------------------------------

  assign is_last = (beat_cnt == route_rec.n_tr);

  // Last beat flag to the region
  assign u_last = route_valid & is_last;

  // Record leaves with its final beat
  assign route_ready = beat & is_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (beat) begin
      if (is_last) begin
        // Next record starts from zero
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dma_rr_arbiter.sv ====
/*
 * Round-robin arbiter merging region read requests onto one DMA engine port.
 * Keeps a routing record per request and a completion record per ctl request,
 * and steers the engine done pulse to the region named by the head record.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_sched_consts.svh"

module dma_rr_arbiter (
  input  logic                                        aclk,
  input  logic                                        aresetn,

  // Region requests and completions
  input  logic [`N_REGIONS-1:0]                       s_valid,
  output logic [`N_REGIONS-1:0]                       s_ready,
  input  dma_sched_pkg::dma_req_t [`N_REGIONS-1:0]    s_req,
  output dma_sched_pkg::dma_rsp_t [`N_REGIONS-1:0]    s_rsp,

  // Engine request port
  output logic                                        m_valid,
  input  logic                                        m_ready,
  output dma_sched_pkg::dma_req_t                     m_req,
  input  logic                                        done_in,

  // Routing records towards the demultiplexer
  output logic                                        route_valid,
  input  logic                                        route_ready,
  output dma_sched_pkg::route_rec_t                   route_rec
);

  import dma_sched_pkg::*;

  logic [`N_REGIONS_BITS-1:0] rr_ptr;
  logic [`N_REGIONS_BITS-1:0] vfid;
  logic                       found;
  logic                       accept;

  // Queue side
  logic                       route_rdy;
  logic                       done_rdy;
  logic                       q_space;
  route_rec_t                 route_in;
  done_rec_t                  done_rec_in;
  logic                       done_valid;
  done_rec_t                  done_head;
  logic [`LEN_BITS-1:0]       len_m1;

  // --------------------------------------------------------------------------
  // Grant
  // --------------------------------------------------------------------------

  // First valid region at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    vfid  = rr_ptr;
    for (int i = 0; i < `N_REGIONS; i++) begin
      idx = (int'(rr_ptr) + i) % `N_REGIONS;
      if (!found && s_valid[idx]) begin
        found = 1'b1;
        vfid  = `N_REGIONS_BITS'(idx);
      end
    end
  end

  // Both records must fit before a request goes out
  assign q_space = route_rdy & done_rdy;

  assign m_valid = found & q_space;
  assign m_req   = s_req[vfid];
  assign accept  = m_valid & m_ready;

  // Only the granted region sees ready
  always_comb begin
    s_ready       = '0;
    s_ready[vfid] = found & q_space & m_ready;
  end

  // Pointer moves one step after each accepted request
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (accept) begin
      rr_ptr <= (rr_ptr == `N_REGIONS_BITS'(`N_REGIONS - 1)) ? '0 : rr_ptr + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Sequence records
  // --------------------------------------------------------------------------

  // Beats minus one
  assign len_m1 = s_req[vfid].len - `LEN_BITS'(1);

  assign route_in.ctl  = s_req[vfid].ctl;
  assign route_in.vfid = vfid;
  assign route_in.n_tr = len_m1[`LEN_BITS-1:BEAT_LOG_BITS];

  assign done_rec_in.stream = s_req[vfid].stream;
  assign done_rec_in.dest   = s_req[vfid].dest;
  assign done_rec_in.vfid   = vfid;
  assign done_rec_in.pid    = s_req[vfid].pid;

  // Every accepted request
  seq_queue #(
    .QTYPE  (route_rec_t),
    .QDEPTH (`N_OUTSTANDING)
  ) inst_route_que (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (accept),
    .rdy_snk  (route_rdy),
    .data_snk (route_in),
    .val_src  (route_valid),
    .rdy_src  (route_ready),
    .data_src (route_rec)
  );

  // Only requests that want a completion
  seq_queue #(
    .QTYPE  (done_rec_t),
    .QDEPTH (`N_OUTSTANDING)
  ) inst_done_que (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (accept & s_req[vfid].ctl),
    .rdy_snk  (done_rdy),
    .data_snk (done_rec_in),
    .val_src  (done_valid),
    .rdy_src  (done_in),
    .data_src (done_head)
  );

  // --------------------------------------------------------------------------
  // Completion steering
  // --------------------------------------------------------------------------

  // Done pulse pops the head record in the same cycle
  always_comb begin
    s_rsp                        = '0;
    s_rsp[done_head.vfid].done   = done_in & done_valid;
    s_rsp[done_head.vfid].pid    = done_head.pid;
    s_rsp[done_head.vfid].dest   = done_head.dest;
    s_rsp[done_head.vfid].stream = done_head.stream;
  end

endmodule

`default_nettype wire

// ==== hdl/seq_queue.sv ====
/*
 * Synchronous FIFO for in-order sequence records.
 * The record type is a parameter, so one module holds routing and completion records.
 */

`timescale 1ns/1ps
`default_nettype none

module seq_queue #(
  parameter type    QTYPE  = logic [7:0],
  parameter integer QDEPTH = 8
) (
  input  logic aclk,
  input  logic aresetn,

  // Write side
  input  logic val_snk,
  output logic rdy_snk,
  input  QTYPE data_snk,

  // Read side
  output logic val_src,
  input  logic rdy_src,
  output QTYPE data_src
);

  localparam integer PTR_BITS = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam integer CNT_BITS = $clog2(QDEPTH + 1);

  QTYPE mem [QDEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_wr;
  logic                do_rd;

  // Not full / not empty
  assign rdy_snk  = (count != CNT_BITS'(QDEPTH));
  assign val_src  = (count != '0);
  assign data_src = mem[rd_ptr];

  assign do_wr = val_snk & rdy_snk;
  assign do_rd = val_src & rdy_src;

  // Storage
  always_ff @(posedge aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_snk;
    end
  end

  // Pointers and occupancy, with wrap for any depth
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous write and read leaves the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dma_sched_pkg.sv ====
/*
 * Types shared by the arbiter, the demultiplexer and the top level.
 * Modules import it by wildcard in the body and use scoped names in ports.
 */

`default_nettype none

`include "dma_sched_consts.svh"

package dma_sched_pkg;

  // Bytes per read beat as a shift amount
  localparam integer BEAT_LOG_BITS = $clog2(`DATA_BITS / 8);
  // Beat count width
  localparam integer BLEN_BITS = `LEN_BITS - BEAT_LOG_BITS;

  // One read request from a region
  typedef struct packed {
    logic [`ADDR_BITS-1:0] vaddr;
    logic [`LEN_BITS-1:0]  len;
    logic                  ctl;
    logic                  stream;
    logic [`DEST_BITS-1:0] dest;
    logic [`PID_BITS-1:0]  pid;
  } dma_req_t;

  // Completion back to a region
  typedef struct packed {
    logic                  done;
    logic [`PID_BITS-1:0]  pid;
    logic [`DEST_BITS-1:0] dest;
    logic                  stream;
  } dma_rsp_t;

  // Where the read beats of one request go
  typedef struct packed {
    logic                       ctl;
    logic [`N_REGIONS_BITS-1:0] vfid;
    logic [BLEN_BITS-1:0]       n_tr;
  } route_rec_t;

  // Who gets the done pulse of one ctl request
  typedef struct packed {
    logic                       stream;
    logic [`DEST_BITS-1:0]      dest;
    logic [`N_REGIONS_BITS-1:0] vfid;
    logic [`PID_BITS-1:0]       pid;
  } done_rec_t;

endpackage

`default_nettype wire

// ==== hdl/dma_sched_consts.svh ====
/*
 * Shared constants of the DMA request scheduler.
 * Included by the package and by every module that sizes ports or counters.
 */

`ifndef DMA_SCHED_CONSTS_SVH
`define DMA_SCHED_CONSTS_SVH

// Region count and index width
`define N_REGIONS      4
`define N_REGIONS_BITS 2

// Depth of each sequence queue
`define N_OUTSTANDING  8

// Bus and field widths
`define DATA_BITS      64
`define LEN_BITS       16
`define PID_BITS       6
`define DEST_BITS      4
`define ADDR_BITS      32

`endif
